// File: common/cache_axi_macros.svh
`ifndef CACHE_AXI_MACROS_SVH
`define CACHE_AXI_MACROS_SVH

// AXI address and data
`define CA_ADDR_W 32
`define CA_DATA_W 32
`define CA_STRB_W 4   // one bit per data byte
`define CA_ID_W 4

// cache side line, four AXI words
`define CA_LINE_W 128

// burst length field, beats minus one
`define CA_LEN_W 8
`define CA_LINE_LEN 3   // 4 beats
`define CA_WORD_LEN 0   // single beat

// outstanding request counters
`define CA_PEND_W 2

`endif

// File: common/cache_axi_pkg.sv
package cache_axi_pkg;

    // cache request size, only LINE changes the burst
    typedef enum logic [2:0] {
        REQ_BYTE = 3'b000,
        REQ_HALF = 3'b001,
        REQ_WORD = 3'b010,
        REQ_LINE = 3'b100
    } req_type_e;

    // requester, carried in bit 0 of arid / rid
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } src_e;

    typedef enum logic [1:0] {
        AR_IDLE,
        AR_REQ,   // arvalid up
        AR_END
    } ar_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_DATA,   // rready up
        R_END
    } r_state_e;

    typedef enum logic [2:0] {
        W_IDLE,
        W_REQ,         // aw and w both open
        W_ADDR_DONE,   // aw taken, w beats left
        W_DATA_DONE,   // last w taken, aw left
        W_WAIT_RESP    // bready up
    } w_state_e;

endpackage

// File: rtl/pending_counter.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module pending_counter #(
    parameter int CNT_W = `CA_PEND_W
) (
    input  logic aclk,
    input  logic areset,
    input  logic issue,    // request handshake
    input  logic retire,   // matching response handshake
    output logic pending,
    output logic full
);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge aclk) begin
        if (areset) begin
            cnt <= '0;
        end else if (issue && !retire) begin
            cnt <= cnt + 1'b1;
        end else if (retire && !issue) begin
            cnt <= cnt - 1'b1;
        end
        // both at once, count holds
    end

    assign pending = |cnt;
    assign full    = &cnt;   // no room for another issue

endmodule

// File: read_path/read_ctrl.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module read_ctrl (
    input  logic                      aclk,
    input  logic                      areset,
    input  logic                      icache_rd_req,
    input  cache_axi_pkg::req_type_e  icache_rd_type,
    input  logic [`CA_ADDR_W-1:0]     icache_rd_addr,
    output logic                      icache_rd_rdy,
    output logic                      icache_ret_valid,
    output logic                      icache_ret_last,
    output logic [`CA_DATA_W-1:0]     icache_ret_data,
    input  logic                      dcache_rd_req,
    input  cache_axi_pkg::req_type_e  dcache_rd_type,
    input  logic [`CA_ADDR_W-1:0]     dcache_rd_addr,
    output logic                      dcache_rd_rdy,
    output logic                      dcache_ret_valid,
    output logic                      dcache_ret_last,
    output logic [`CA_DATA_W-1:0]     dcache_ret_data,
    output logic [`CA_ID_W-1:0]       arid,
    output logic [`CA_ADDR_W-1:0]     araddr,
    output logic [`CA_LEN_W-1:0]      arlen,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [`CA_ID_W-1:0]       rid,
    input  logic [`CA_DATA_W-1:0]     rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic                      write_busy,
    input  logic [`CA_ADDR_W-1:0]     awaddr,
    input  logic                      rd_pending,
    input  logic                      rd_full,
    output logic                      ar_fire,
    output logic                      r_last_fire
);

    cache_axi_pkg::ar_state_e ar_state;
    cache_axi_pkg::r_state_e  r_state;
    cache_axi_pkg::src_e      ar_src;     // requester of the captured read
    cache_axi_pkg::src_e      rsp_src;    // requester of the current R beat
    cache_axi_pkg::req_type_e cand_type;
    logic [`CA_ADDR_W-1:0]    cand_addr;
    logic                     rd_block;
    logic                     ar_free;
    logic                     accept;

    // dcache wins, so candidate follows its req
    assign cand_addr = dcache_rd_req ? dcache_rd_addr : icache_rd_addr;
    assign cand_type = dcache_rd_req ? dcache_rd_type : icache_rd_type;

    // read after write to the same address waits for B
    assign rd_block = write_busy && (cand_addr == awaddr);
    assign ar_free  = (ar_state == cache_axi_pkg::AR_IDLE) && !rd_pending && !rd_full;

    assign dcache_rd_rdy = ar_free && !rd_block;
    assign icache_rd_rdy = ar_free && !rd_block && !dcache_rd_req;   // yields to dcache
    assign accept = (dcache_rd_req && dcache_rd_rdy) || (icache_rd_req && icache_rd_rdy);

    always_ff @(posedge aclk) begin
        if (areset) begin
            ar_state <= cache_axi_pkg::AR_IDLE;
        end else begin
            case (ar_state)
                cache_axi_pkg::AR_IDLE: if (accept) ar_state <= cache_axi_pkg::AR_REQ;
                cache_axi_pkg::AR_REQ:  if (ar_fire) ar_state <= cache_axi_pkg::AR_END;
                default:                ar_state <= cache_axi_pkg::AR_IDLE;
            endcase
        end
    end

    // address, id and length latched while idle, frozen once arvalid is up
    always_ff @(posedge aclk) begin
        if (ar_state == cache_axi_pkg::AR_IDLE) begin
            ar_src <= dcache_rd_req ? cache_axi_pkg::SRC_DCACHE : cache_axi_pkg::SRC_ICACHE;
            araddr <= cand_addr;
            arlen  <= (cand_type == cache_axi_pkg::REQ_LINE) ? `CA_LEN_W'(`CA_LINE_LEN)
                                                              : `CA_LEN_W'(`CA_WORD_LEN);
        end
    end

    assign arid    = {{(`CA_ID_W-1){1'b0}}, ar_src};
    assign arvalid = (ar_state == cache_axi_pkg::AR_REQ);
    assign ar_fire = arvalid && arready;

    // R side opens after the AR handshake, or while one is still owed data
    always_ff @(posedge aclk) begin
        if (areset) begin
            r_state <= cache_axi_pkg::R_IDLE;
        end else begin
            case (r_state)
                cache_axi_pkg::R_IDLE: begin
                    if (ar_fire || rd_pending) r_state <= cache_axi_pkg::R_DATA;
                end
                cache_axi_pkg::R_DATA: if (r_last_fire) r_state <= cache_axi_pkg::R_END;
                default:               r_state <= cache_axi_pkg::R_IDLE;
            endcase
        end
    end

    assign rready      = (r_state == cache_axi_pkg::R_DATA);
    assign r_last_fire = rvalid && rready && rlast;

    // return routing on rid bit 0, same cycle as the beat
    assign rsp_src          = cache_axi_pkg::src_e'(rid[0]);
    assign icache_ret_valid = rvalid && rready && (rsp_src == cache_axi_pkg::SRC_ICACHE);
    assign dcache_ret_valid = rvalid && rready && (rsp_src == cache_axi_pkg::SRC_DCACHE);
    assign icache_ret_last  = icache_ret_valid && rlast;
    assign dcache_ret_last  = dcache_ret_valid && rlast;
    assign icache_ret_data  = rdata;   // shared bus, valid picks the owner
    assign dcache_ret_data  = rdata;

endmodule

// File: write_path/write_ctrl.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module write_ctrl (
    input  logic                     aclk,
    input  logic                     areset,
    input  logic                     dcache_wr_req,
    input  cache_axi_pkg::req_type_e dcache_wr_type,
    input  logic [`CA_ADDR_W-1:0]    dcache_wr_addr,
    output logic                     dcache_wr_rdy,
    output logic [`CA_ADDR_W-1:0]    awaddr,
    output logic [`CA_LEN_W-1:0]     awlen,
    output logic                     awvalid,
    input  logic                     awready,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     wlast,
    input  logic                     bvalid,
    output logic                     bready,
    output logic                     write_busy,
    output logic                     load,
    output logic                     is_line,
    input  logic                     wr_pending,
    output logic                     aw_fire,
    output logic                     b_fire
);

    cache_axi_pkg::w_state_e w_state;
    logic                    w_last_fire;

    assign is_line = (dcache_wr_type == cache_axi_pkg::REQ_LINE);
    assign load    = dcache_wr_req && dcache_wr_rdy;   // accept pulse, buffer takes the data

    assign aw_fire     = awvalid && awready;
    assign w_last_fire = wvalid && wready && wlast;
    assign b_fire      = bvalid && bready;

    // aw and last w may finish in either order, or together
    always_ff @(posedge aclk) begin
        if (areset) begin
            w_state <= cache_axi_pkg::W_IDLE;
        end else begin
            case (w_state)
                cache_axi_pkg::W_IDLE: begin
                    if (load) w_state <= cache_axi_pkg::W_REQ;
                end
                cache_axi_pkg::W_REQ: begin
                    if (aw_fire && w_last_fire) begin
                        w_state <= cache_axi_pkg::W_WAIT_RESP;
                    end else if (aw_fire) begin
                        w_state <= cache_axi_pkg::W_ADDR_DONE;
                    end else if (w_last_fire) begin
                        w_state <= cache_axi_pkg::W_DATA_DONE;
                    end
                end
                cache_axi_pkg::W_ADDR_DONE: begin
                    if (w_last_fire) w_state <= cache_axi_pkg::W_WAIT_RESP;   // beats still going
                end
                cache_axi_pkg::W_DATA_DONE: begin
                    if (aw_fire) w_state <= cache_axi_pkg::W_WAIT_RESP;
                end
                cache_axi_pkg::W_WAIT_RESP: begin
                    if (b_fire) w_state <= cache_axi_pkg::W_IDLE;
                end
                default: w_state <= cache_axi_pkg::W_IDLE;
            endcase
        end
    end

    // address and length held from acceptance to B
    always_ff @(posedge aclk) begin
        if (w_state == cache_axi_pkg::W_IDLE) begin
            awaddr <= dcache_wr_addr;
            awlen  <= is_line ? `CA_LEN_W'(`CA_LINE_LEN) : `CA_LEN_W'(`CA_WORD_LEN);
        end
    end

    assign awvalid = (w_state == cache_axi_pkg::W_REQ) || (w_state == cache_axi_pkg::W_DATA_DONE);
    assign wvalid  = (w_state == cache_axi_pkg::W_REQ) || (w_state == cache_axi_pkg::W_ADDR_DONE);
    assign bready  = (w_state == cache_axi_pkg::W_WAIT_RESP);

    assign write_busy    = (w_state != cache_axi_pkg::W_IDLE);   // feeds the read block
    assign dcache_wr_rdy = (w_state == cache_axi_pkg::W_IDLE) && !wr_pending;

endmodule

// File: write_path/write_buffer.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module write_buffer (
    input  logic                  aclk,
    input  logic                  areset,
    input  logic                  load,
    input  logic                  is_line,
    input  logic [`CA_STRB_W-1:0] dcache_wr_wstrb,
    input  logic [`CA_LINE_W-1:0] dcache_wr_data,
    input  logic                  wvalid,
    input  logic                  wready,
    output logic [`CA_DATA_W-1:0] wdata,
    output logic [`CA_STRB_W-1:0] wstrb,
    output logic                  wlast
);

    logic [`CA_LINE_W-1:0] line_q;     // low word is the next beat
    logic [`CA_STRB_W-1:0] strb_q;
    logic [`CA_LEN_W-1:0]  beat_cnt;   // beats left after the current one
    logic                  w_fire;

    assign w_fire = wvalid && wready;

    // payload, shifted down one word per W handshake
    always_ff @(posedge aclk) begin
        if (load) begin
            line_q <= dcache_wr_data;
            strb_q <= dcache_wr_wstrb;
        end else if (w_fire) begin
            line_q <= {{`CA_DATA_W{1'b0}}, line_q[`CA_LINE_W-1:`CA_DATA_W]};
        end
    end

    always_ff @(posedge aclk) begin
        if (areset) begin
            beat_cnt <= '0;
        end else if (load) begin
            beat_cnt <= is_line ? `CA_LEN_W'(`CA_LINE_LEN) : `CA_LEN_W'(`CA_WORD_LEN);
        end else if (w_fire && (beat_cnt != '0)) begin
            beat_cnt <= beat_cnt - 1'b1;   // parks at zero after the last beat
        end
    end

    assign wdata = line_q[`CA_DATA_W-1:0];
    assign wstrb = strb_q;   // same strobes on every beat
    assign wlast = (beat_cnt == '0);

endmodule

// File: rtl/cache_axi_bridge.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module cache_axi_bridge (
    input  logic                     aclk,
    input  logic                     areset,
    output logic [`CA_ID_W-1:0]      arid,
    output logic [`CA_ADDR_W-1:0]    araddr,
    output logic [`CA_LEN_W-1:0]     arlen,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [`CA_ID_W-1:0]      rid,
    input  logic [`CA_DATA_W-1:0]    rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    output logic [`CA_ADDR_W-1:0]    awaddr,
    output logic [`CA_LEN_W-1:0]     awlen,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`CA_DATA_W-1:0]    wdata,
    output logic [`CA_STRB_W-1:0]    wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready,
    input  logic                     icache_rd_req,
    input  cache_axi_pkg::req_type_e icache_rd_type,
    input  logic [`CA_ADDR_W-1:0]    icache_rd_addr,
    output logic                     icache_rd_rdy,
    output logic                     icache_ret_valid,
    output logic                     icache_ret_last,
    output logic [`CA_DATA_W-1:0]    icache_ret_data,
    input  logic                     dcache_rd_req,
    input  cache_axi_pkg::req_type_e dcache_rd_type,
    input  logic [`CA_ADDR_W-1:0]    dcache_rd_addr,
    output logic                     dcache_rd_rdy,
    output logic                     dcache_ret_valid,
    output logic                     dcache_ret_last,
    output logic [`CA_DATA_W-1:0]    dcache_ret_data,
    input  logic                     dcache_wr_req,
    input  cache_axi_pkg::req_type_e dcache_wr_type,
    input  logic [`CA_ADDR_W-1:0]    dcache_wr_addr,
    input  logic [`CA_STRB_W-1:0]    dcache_wr_wstrb,
    input  logic [`CA_LINE_W-1:0]    dcache_wr_data,
    output logic                     dcache_wr_rdy
);

    logic write_busy;    // write in flight, for the read block
    logic load;
    logic is_line;
    logic rd_pending;
    logic rd_full;
    logic wr_pending;
    logic ar_fire;
    logic r_last_fire;
    logic aw_fire;
    logic b_fire;

    read_ctrl u_read_ctrl (.*);

    write_ctrl u_write_ctrl (.*);

    write_buffer u_write_buffer (.*);

    // AR handshakes not yet closed by rlast
    pending_counter #(.CNT_W(`CA_PEND_W)) u_rd_pending (
        .aclk    (aclk),
        .areset  (areset),
        .issue   (ar_fire),
        .retire  (r_last_fire),
        .pending (rd_pending),
        .full    (rd_full)
    );

    // AW handshakes not yet answered on B, full flag left open
    pending_counter #(.CNT_W(`CA_PEND_W)) u_wr_pending (
        .aclk    (aclk),
        .areset  (areset),
        .issue   (aw_fire),
        .retire  (b_fire),
        .pending (wr_pending),
        .full    ()
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 50,   // 100 ns clock
    parameter int RESET_CYCLES = 2
) (
    output logic aclk,
    output logic areset
);

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    // reset held over the first edges, released on an edge
    initial begin
        areset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        areset <= 1'b0;
    end

endmodule

// File: verification/tb_cache_axi_bridge.sv
`timescale 1ns/100ps
`include "cache_axi_macros.svh"

module tb_cache_axi_bridge;

    localparam int MAX_CYCLES = 2000;   // 6 tests of ~60 cycles, x5 margin

    logic aclk, areset;
    logic [3:0] arid, rid = '0;
    logic [31:0] araddr, rdata = '0, awaddr, wdata;
    logic [7:0] arlen, awlen;
    logic arvalid, arready = 1'b0, rlast = 1'b0, rvalid = 1'b0, rready;
    logic awvalid, awready = 1'b0, wvalid, wready = 1'b0, wlast, bvalid = 1'b0, bready;
    logic [3:0] wstrb;
    logic icache_rd_req, icache_rd_rdy, icache_ret_valid, icache_ret_last;
    logic dcache_rd_req, dcache_rd_rdy, dcache_ret_valid, dcache_ret_last;
    logic dcache_wr_req, dcache_wr_rdy;
    cache_axi_pkg::req_type_e icache_rd_type, dcache_rd_type, dcache_wr_type;
    logic [31:0] icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
    logic [31:0] icache_ret_data, dcache_ret_data;
    logic [3:0] dcache_wr_wstrb;
    logic [127:0] dcache_wr_data;

    integer seed = 32'h3508b77a;
    int errors = 0, tests_pass = 0, tests_fail = 0, cycles = 0, b_cnt = 0;
    logic raw_check = 1'b0;          // read to a write address is pending
    logic [31:0] mem [64];           // slave memory
    logic [31:0] exp_mem [64];       // expected contents
    logic [31:0] ic_q[$], dc_q[$], w_data_q[$];
    logic ic_last_q[$], dc_last_q[$], w_last_q[$];
    logic [3:0] ar_id_q[$], w_strb_q[$];
    logic [7:0] ar_len_q[$], aw_len_q[$];

    // slave state
    logic ar_busy = 1'b0, aw_got = 1'b0, w_done = 1'b0;
    logic [3:0] r_id = '0;
    logic [5:0] r_idx = '0, aw_idx = '0;
    logic [7:0] r_left = '0;
    int ar_wait = 0, r_wait = 0, aw_wait = 0, w_wait = 0, b_wait = 0;

    tb_clock_gen u_clock_gen (.aclk(aclk), .areset(areset));

    cache_axi_bridge i_dut (.*);

    function automatic logic [31:0] fill_word(input int idx);
        fill_word = 32'h5a00_0000 ^ (idx << 20) ^ (idx * 32'h0001_0203);   // whole index
    endfunction

    function automatic int rand_delay();
        rand_delay = $unsigned($random(seed)) % 4;   // 0 to 3 cycles
    endfunction

    // AXI memory slave, one read and one write at a time
    always @(posedge aclk) begin
        if (areset) begin
            for (int i = 0; i < 64; i++) mem[i] <= fill_word(i);
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_busy <= 1'b1;
                r_id    <= arid;
                r_idx   <= araddr[7:2];
                r_left  <= arlen;
                r_wait  <= rand_delay();
                ar_wait <= rand_delay();
            end else if (arvalid && !ar_busy && ar_wait == 0) begin
                arready <= 1'b1;
            end else if (ar_wait != 0) begin
                ar_wait <= ar_wait - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_idx  <= r_idx + 1'b1;
                r_left <= r_left - 1'b1;
                r_wait <= rand_delay();
                if (rlast) ar_busy <= 1'b0;
            end else if (ar_busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[r_idx];
                    rid    <= r_id;
                    rlast  <= (r_left == 0);
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                aw_idx  <= awaddr[7:2];
                aw_wait <= rand_delay();
            end else if (awvalid && !aw_got && aw_wait == 0) begin
                awready <= 1'b1;
            end else if (aw_wait != 0) begin
                aw_wait <= aw_wait - 1;
            end
            // W only after AW, so the beat address is known
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) mem[aw_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
                aw_idx <= aw_idx + 1'b1;
                wready <= 1'b0;
                w_wait <= rand_delay();
                if (wlast) begin
                    w_done <= 1'b1;
                    b_wait <= rand_delay();
                end
            end else if (wvalid && aw_got && !w_done && w_wait == 0) begin
                wready <= 1'b1;
            end else if (w_wait != 0) begin
                w_wait <= w_wait - 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_done <= 1'b0;
            end else if (w_done && !bvalid) begin
                if (b_wait == 0) bvalid <= 1'b1;
                else b_wait <= b_wait - 1;
            end
        end
    end

    // channel monitor
    always @(posedge aclk) begin
        if (!areset) begin
            if (arvalid && arready) begin
                ar_id_q.push_back(arid);
                ar_len_q.push_back(arlen);
            end
            if (icache_ret_valid) begin
                ic_q.push_back(icache_ret_data);
                ic_last_q.push_back(icache_ret_last);
            end
            if (dcache_ret_valid) begin
                dc_q.push_back(dcache_ret_data);
                dc_last_q.push_back(dcache_ret_last);
            end
            if (awvalid && awready) aw_len_q.push_back(awlen);
            if (wvalid && wready) begin
                w_data_q.push_back(wdata);
                w_strb_q.push_back(wstrb);
                w_last_q.push_back(wlast);
            end
            if (bvalid && bready) b_cnt <= b_cnt + 1;
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a test never completed", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // protocol rules
    assert property (@(posedge aclk) disable iff (areset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
        errors++;
        $display("arvalid dropped or AR payload changed before arready");
    end
    assert property (@(posedge aclk) disable iff (areset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
        errors++;
        $display("awvalid dropped or awaddr changed before awready");
    end
    assert property (@(posedge aclk) disable iff (areset)
        wvalid && !wready |=> wvalid && $stable(wdata))
    else begin
        errors++;
        $display("wvalid dropped or wdata changed before wready");
    end
    // no new read taken while one is outstanding
    assert property (@(posedge aclk) disable iff (areset)
        arvalid || rready |-> !icache_rd_rdy && !dcache_rd_rdy)
    else begin
        errors++;
        $display("a read rdy was high while a read was outstanding");
    end
    assert property (@(posedge aclk) disable iff (areset) raw_check |-> !arvalid)
    else begin
        errors++;
        $display("read issued before the write to its address finished");
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_logs();
        ic_q.delete();
        ic_last_q.delete();
        dc_q.delete();
        dc_last_q.delete();
        ar_id_q.delete();
        ar_len_q.delete();
        aw_len_q.delete();
        w_data_q.delete();
        w_strb_q.delete();
        w_last_q.delete();
    endtask

    // raise reads together, drop each req on its own acceptance
    task automatic read_pair(input logic do_i, input cache_axi_pkg::req_type_e ti,
                             input logic [31:0] ai, input logic do_d,
                             input cache_axi_pkg::req_type_e td, input logic [31:0] ad);
        logic i_wait;
        logic d_wait;
        @(posedge aclk);
        icache_rd_req  <= do_i;
        icache_rd_type <= ti;
        icache_rd_addr <= ai;
        dcache_rd_req  <= do_d;
        dcache_rd_type <= td;
        dcache_rd_addr <= ad;
        i_wait = do_i;
        d_wait = do_d;
        while (i_wait || d_wait) begin
            @(posedge aclk);
            if (dcache_rd_req && dcache_rd_rdy) begin
                dcache_rd_req <= 1'b0;
                d_wait = 1'b0;
            end
            if (icache_rd_req && icache_rd_rdy) begin
                icache_rd_req <= 1'b0;
                i_wait = 1'b0;
            end
        end
    endtask

    task automatic write_req(input cache_axi_pkg::req_type_e t, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [127:0] data);
        @(posedge aclk);
        dcache_wr_req   <= 1'b1;
        dcache_wr_type  <= t;
        dcache_wr_addr  <= addr;
        dcache_wr_wstrb <= strb;
        dcache_wr_data  <= data;
        do @(posedge aclk); while (!(dcache_wr_req && dcache_wr_rdy));
        dcache_wr_req <= 1'b0;
        for (int k = 0; k < ((t == cache_axi_pkg::REQ_LINE) ? 4 : 1); k++) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) exp_mem[addr[7:2] + k][8*b +: 8] = data[32*k + 8*b +: 8];
            end
        end
    endtask

    // waits for the beats, then compares data and last flags
    task automatic check_read(input int ni, input int idx_i, input int nd, input int idx_d);
        while (ic_q.size() < ni || dc_q.size() < nd) @(posedge aclk);
        repeat (3) @(posedge aclk);   // catch stray beats
        check_val("icache beat count", ic_q.size(), ni);
        check_val("dcache beat count", dc_q.size(), nd);
        for (int k = 0; k < ni && k < ic_q.size(); k++) begin
            check_val("icache_ret_data", ic_q[k], exp_mem[idx_i + k]);
            check_val("icache_ret_last", ic_last_q[k], k == ni - 1);
        end
        for (int k = 0; k < nd && k < dc_q.size(); k++) begin
            check_val("dcache_ret_data", dc_q[k], exp_mem[idx_d + k]);
            check_val("dcache_ret_last", dc_last_q[k], k == nd - 1);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_pass++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: fail", num, name);
        end
    endtask

    initial begin
        int e;
        int b_old;
        icache_rd_req = 1'b0;
        icache_rd_type = cache_axi_pkg::REQ_WORD;
        icache_rd_addr = '0;
        dcache_rd_req = 1'b0;
        dcache_rd_type = cache_axi_pkg::REQ_WORD;
        dcache_rd_addr = '0;
        dcache_wr_req = 1'b0;
        dcache_wr_type = cache_axi_pkg::REQ_WORD;
        dcache_wr_addr = '0;
        dcache_wr_wstrb = '0;
        dcache_wr_data = '0;
        for (int i = 0; i < 64; i++) exp_mem[i] = fill_word(i);
        do @(posedge aclk); while (areset);
        @(posedge aclk);

        e = errors;
        check_val("arvalid", arvalid, 0);
        check_val("awvalid", awvalid, 0);
        check_val("wvalid", wvalid, 0);
        check_val("rready", rready, 0);
        check_val("bready", bready, 0);
        check_val("icache_rd_rdy", icache_rd_rdy, 1);
        check_val("dcache_rd_rdy", dcache_rd_rdy, 1);
        check_val("dcache_wr_rdy", dcache_wr_rdy, 1);
        end_test(1, "reset values", e);

        e = errors;
        clear_logs();
        read_pair(1, cache_axi_pkg::REQ_WORD, 32'h10, 0, cache_axi_pkg::REQ_WORD, 0);
        check_read(1, 4, 0, 0);
        check_val("arlen", ar_len_q[0], 0);
        check_val("arid[0]", ar_id_q[0][0], 0);
        end_test(2, "icache word read", e);

        e = errors;
        clear_logs();
        read_pair(0, cache_axi_pkg::REQ_WORD, 0, 1, cache_axi_pkg::REQ_LINE, 32'h40);
        check_read(0, 0, 4, 16);
        check_val("arlen", ar_len_q[0], 3);
        check_val("arid[0]", ar_id_q[0][0], 1);
        end_test(3, "dcache line read", e);

        e = errors;
        clear_logs();
        read_pair(1, cache_axi_pkg::REQ_WORD, 32'h30, 1, cache_axi_pkg::REQ_WORD, 32'h20);
        check_read(1, 12, 1, 8);
        check_val("first arid[0]", ar_id_q[0][0], 1);
        end_test(4, "dcache wins arbitration", e);

        e = errors;
        clear_logs();
        b_old = b_cnt;
        write_req(cache_axi_pkg::REQ_LINE, 32'h80, 4'b1011,
                  128'h4444_4444_3333_3333_2222_2222_1111_1111);
        while (b_cnt == b_old) @(posedge aclk);
        check_val("awlen", aw_len_q[0], 3);
        check_val("W beat count", w_data_q.size(), 4);
        for (int k = 0; k < 4 && k < w_data_q.size(); k++) begin
            check_val("wdata", w_data_q[k], {8{4'(k + 1)}});
            check_val("wstrb", w_strb_q[k], 4'b1011);
            check_val("wlast", w_last_q[k], k == 3);
        end
        read_pair(0, cache_axi_pkg::REQ_WORD, 0, 1, cache_axi_pkg::REQ_LINE, 32'h80);
        check_read(0, 0, 4, 32);
        end_test(5, "dcache line write", e);

        e = errors;
        clear_logs();
        b_old = b_cnt;
        write_req(cache_axi_pkg::REQ_WORD, 32'hc0, 4'hf, 128'h1234_5678);
        raw_check = 1'b1;
        fork
            read_pair(1, cache_axi_pkg::REQ_WORD, 32'hc0, 0, cache_axi_pkg::REQ_WORD, 0);
            begin
                while (b_cnt == b_old) @(posedge aclk);
                raw_check = 1'b0;   // B done, the read may go
            end
        join
        check_read(1, 48, 0, 0);
        end_test(6, "read after write block", e);

        $display("tests passed %0d, failed %0d, check errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: cache_axi_bridge.f
+incdir+common
common/cache_axi_pkg.sv
rtl/pending_counter.sv
read_path/read_ctrl.sv
write_path/write_ctrl.sv
write_path/write_buffer.sv
rtl/cache_axi_bridge.sv
verification/tb_clock_gen.sv
verification/tb_cache_axi_bridge.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f cache_axi_bridge.f \
    --top-module tb_cache_axi_bridge -o sim_tb || exit 1
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^NO ERRORS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
